// ==== verilog.f ====
verilog/ebi_pkg.sv
verilog/sampler_pkg.sv
verilog/ebi_port.sv
verilog/collect_fsm.sv
verilog/channel_slot.sv
verilog/sample_store.sv
verilog/sample_collector.sv
verif/sample_collector_tb.sv

// ==== Makefile ====
TOP = sample_collector_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module sample_collector

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== verif/sample_collector_tb.sv ====
//----------------------------------------
// testbench for the sample collector
// applies a table of bus steps and checks every register read
// the ADC is modelled by a per-channel value table and its strobe is watched
//----------------------------------------
module sample_collector_tb;
  import ebi_pkg::*;
  import sampler_pkg::*;

  localparam int access_len = 5;
  localparam int max_steps  = 40;
  localparam int margin     = 200;

  typedef enum logic [1:0] {
    k_write,
    k_read,
    k_wait,
    k_adc
  } step_kind_e;

  logic                clk;
  logic                rst;
  logic [addr_w-1:0]   addr;
  logic [data_w-1:0]   wdata;
  logic                cs;
  logic                re;
  logic                wr;
  logic [sample_w-1:0] sample_data;
  logic [data_w-1:0]   rdata;
  logic                output_sample;
  logic [chan_w-1:0]   channel_select;

  //----------------------------------------
  // stimulus table
  //----------------------------------------
  step_kind_e          step_kind [max_steps];
  string               step_name [max_steps];
  logic [addr_w-1:0]   step_addr [max_steps];
  logic [31:0]         step_data [max_steps];
  logic [data_w-1:0]   step_exp  [max_steps];
  int                  num_steps;
  int                  total_cycles;
  int                  cycle_limit;
  int                  cycles;
  int                  checks;
  int                  errors;

  // ADC model state
  logic [sample_w-1:0] adc_val [256];
  bit                  low_used [8192];
  logic [31:0]         rng;
  logic [chan_w-1:0]   chans [4];

  // strobe monitor state
  int                  strobe_len;
  int                  since_rise;
  int                  exp_slot;
  bit                  strobe_seen;

  sample_collector i_sample_collector (
    .clk, .rst, .addr, .wdata, .cs, .re, .wr, .sample_data,
    .rdata, .output_sample, .channel_select
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // conversion result follows the selected channel while the strobe is high
  always @(posedge clk) begin
    #1;
    if (output_sample) begin
      sample_data = adc_val[channel_select];
    end
  end

  //----------------------------------------
  // ADC strobe monitor
  //----------------------------------------
  // two cycles high, one slot every four cycles, registered channels in slot order
  always @(posedge clk) begin
    #1;
    if (channel_select === 8'hff) begin
      exp_slot    = 0;
      since_rise  = 0;
      strobe_seen = 1'b0;
    end
    if ((output_sample === 1'b1) && (strobe_len == 0)) begin
      checks++;
      assert (channel_select === chans[exp_slot]) else begin
        $display("MISMATCH strobe channel slot %0d expected %h actual %h",
                 exp_slot, chans[exp_slot], channel_select);
        errors++;
      end
      if (strobe_seen) begin
        checks++;
        assert (since_rise == 4) else begin
          $display("MISMATCH strobe period expected %0d actual %0d", 4, since_rise);
          errors++;
        end
      end
      exp_slot    = (exp_slot + 1) % 4;
      since_rise  = 0;
      strobe_seen = 1'b1;
    end
    if (output_sample === 1'b1) begin
      strobe_len++;
    end else if (strobe_len != 0) begin
      checks++;
      assert (strobe_len == 2) else begin
        $display("MISMATCH strobe width expected %0d actual %0d", 2, strobe_len);
        errors++;
      end
      strobe_len = 0;
    end
    if (strobe_seen) begin
      since_rise++;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the step table did not complete", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [addr_w-1:0] unit_reg(input logic [7:0] unit, input logic [7:0] off);
    return {3'b000, unit, off};
  endfunction

  // slot number sits above the low 13 sample bits
  function automatic logic [15:0] make_record(input logic [2:0] slot, input logic [31:0] v);
    return {slot, v[12:0]};
  endfunction

  // nonzero and not yet used in the low 13 bits
  task automatic draw_sample(output logic [31:0] v);
    do begin
      rng = lcg_step(rng);
      v = rng;
    end while ((v[12:0] == 13'd0) || low_used[v[12:0]]);
    low_used[v[12:0]] = 1'b1;
  endtask

  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic add_step(input step_kind_e kind, input string name,
                          input logic [addr_w-1:0] a, input logic [31:0] d,
                          input logic [data_w-1:0] e);
    step_kind[num_steps] = kind;
    step_name[num_steps] = name;
    step_addr[num_steps] = a;
    step_data[num_steps] = d;
    step_exp[num_steps]  = e;
    if ((kind == k_write) || (kind == k_read)) begin
      total_cycles += access_len;
    end else if (kind == k_wait) begin
      total_cycles += int'(d);
    end
    num_steps++;
  endtask

  task automatic bus_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    addr  = a;
    wdata = d;
    cs    = 1'b1;
    wr    = 1'b1;
    tick(1);
    cs = 1'b0;
    wr = 1'b0;
    tick(access_len - 1);
  endtask

  // rdata is registered, so it is valid in the cycle after re is seen
  task automatic bus_read(input logic [addr_w-1:0] a, output logic [data_w-1:0] got);
    addr = a;
    cs   = 1'b1;
    re   = 1'b1;
    tick(1);
    got = rdata;
    cs  = 1'b0;
    re  = 1'b0;
    tick(access_len - 1);
  endtask

  task automatic check_value(input string name, input logic [data_w-1:0] exp,
                             input logic [data_w-1:0] got);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH %s expected %h actual %h", name, exp, got);
      errors++;
    end
    if (got === exp) begin
      $display("ok       %s = %h", name, got);
    end
  endtask

  task automatic run_step(input int n);
    logic [data_w-1:0] got;
    case (step_kind[n])
      k_write: bus_write(step_addr[n], step_data[n][data_w-1:0]);
      k_read: begin
        bus_read(step_addr[n], got);
        check_value(step_name[n], step_exp[n], got);
      end
      k_wait:  tick(int'(step_data[n]));
      default: adc_val[step_addr[n][7:0]] = step_data[n];
    endcase
  endtask

  //----------------------------------------
  // table contents
  //----------------------------------------
  task automatic build_table();
    logic [31:0] v [4];
    logic [31:0] n1;
    logic [31:0] n3;
    logic [7:0]  me;
    int          c;
    me = 8'(unit_position);
    chans = '{8'd3, 8'd17, 8'd42, 8'd96};
    for (c = 0; c < 256; c++) begin
      draw_sample(adc_val[c]);
    end
    for (c = 0; c < 4; c++) begin
      v[c] = adc_val[chans[c]];
    end
    draw_sample(n1);
    draw_sample(n3);

    add_step(k_read, "debug word", unit_reg(me, reg_debug), 0, 16'hbaab);
    add_step(k_read, "other unit", unit_reg(8'd241, reg_debug), 0, 16'h0000);
    add_step(k_read, "units at reset", unit_reg(me, reg_num_units), 0, 16'd0);
    for (c = 0; c < 4; c++) begin
      add_step(k_write, "new unit", unit_reg(me, reg_new_unit), 32'(chans[c]), 0);
    end
    add_step(k_read, "num units", unit_reg(me, reg_num_units), 0, 16'd4);

    // first run, only the first capture of each slot is new
    add_step(k_write, "start", unit_reg(me, reg_command), 32'(cmd_start), 0);
    add_step(k_wait, "run 1", '0, 64, 0);
    add_step(k_write, "stop", unit_reg(me, reg_command), 32'(cmd_stop), 0);
    add_step(k_wait, "settle 1", '0, 24, 0);
    add_step(k_read, "samples run 1", unit_reg(me, reg_num_samples), 0, 16'd4);

    // second run with slots 1 and 3 changed
    add_step(k_adc, "adc slot 1", addr_w'(chans[1]), n1, 0);
    add_step(k_adc, "adc slot 3", addr_w'(chans[3]), n3, 0);
    add_step(k_write, "start", unit_reg(me, reg_command), 32'(cmd_start), 0);
    add_step(k_wait, "run 2", '0, 40, 0);
    add_step(k_write, "stop", unit_reg(me, reg_command), 32'(cmd_stop), 0);
    add_step(k_wait, "settle 2", '0, 24, 0);
    add_step(k_read, "samples run 2", unit_reg(me, reg_num_samples), 0, 16'd6);

    for (c = 0; c < 4; c++) begin
      add_step(k_read, $sformatf("record %0d", c), unit_reg(me, reg_next_sample), 0,
               make_record(3'(c), v[c]));
    end
    add_step(k_read, "record 4", unit_reg(me, reg_next_sample), 0, make_record(3'd1, n1));
    add_step(k_read, "record 5", unit_reg(me, reg_next_sample), 0, make_record(3'd3, n3));
    add_step(k_read, "read addr", unit_reg(me, reg_read_addr), 0, 16'd6);

    add_step(k_write, "reset cmd", unit_reg(me, reg_command), 32'(cmd_reset), 0);
    add_step(k_wait, "settle 3", '0, 4, 0);
    add_step(k_read, "samples cleared", unit_reg(me, reg_num_samples), 0, 16'd0);
    add_step(k_read, "units cleared", unit_reg(me, reg_num_units), 0, 16'd0);
    add_step(k_read, "read addr cleared", unit_reg(me, reg_read_addr), 0, 16'd0);
  endtask

  initial begin : main
    int n;
    rst          = 1'b1;
    addr         = '0;
    wdata        = '0;
    cs           = 1'b0;
    re           = 1'b0;
    wr           = 1'b0;
    sample_data  = '0;
    cycles       = 0;
    checks       = 0;
    errors       = 0;
    num_steps    = 0;
    total_cycles = 0;
    strobe_len   = 0;
    since_rise   = 0;
    exp_slot     = 0;
    strobe_seen  = 1'b0;
    rng          = 32'hc7017e37;
    build_table();
    cycle_limit = 5 + total_cycles + margin;

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    tick(2);

    // ADC side is quiet until sampling starts
    check_value("strobe after reset", 16'd0, 16'(output_sample));
    check_value("channel after reset", 16'h00ff, 16'(channel_select));

    for (n = 0; n < num_steps; n++) begin
      run_step(n);
    end

    $display("%0d checks done, %0d failed", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== verilog/sample_collector.sv ====
//----------------------------------------
// sample collector top level
// EBI peripheral that round-robins ADC channels into a sample memory
//----------------------------------------
module sample_collector (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [ebi_pkg::addr_w-1:0]        addr,
  input  logic [ebi_pkg::data_w-1:0]        wdata,
  input  logic                              cs,
  input  logic                              re,
  input  logic                              wr,
  input  logic [sampler_pkg::sample_w-1:0]  sample_data,
  output logic [ebi_pkg::data_w-1:0]        rdata,
  output logic                              output_sample,
  output logic [sampler_pkg::chan_w-1:0]    channel_select
);
  import ebi_pkg::*;
  import sampler_pkg::*;

  cmd_e                               cmd;
  logic                               cmd_clear;
  logic                               clear;
  logic                               unit_we;
  logic [slot_w-1:0]                  unit_slot;
  logic [chan_w-1:0]                  unit_chan;
  logic [slot_w:0]                    num_units;
  logic                               rd_advance;
  logic [rec_w-1:0]                   rd_word;
  logic [ptr_w-1:0]                   num_samples;
  logic [ptr_w-1:0]                   read_ptr;
  logic [slot_w-1:0]                  cur_slot;
  logic                               capture;
  logic                               commit;
  logic [num_slots-1:0][chan_w-1:0]   chan_ids;
  logic [num_slots-1:0][rec_w-1:0]    records;
  logic [num_slots-1:0]               changed_flags;

  ebi_port i_ebi_port (
    .clk, .rst, .addr, .wdata, .cs, .re, .wr, .rdata,
    .cmd, .cmd_clear, .clear,
    .unit_we, .unit_slot, .unit_chan, .num_units,
    .rd_advance, .rd_word, .num_samples, .read_ptr
  );

  collect_fsm i_collect_fsm (
    .clk, .rst, .cmd, .num_units, .chan_ids,
    .cmd_clear, .clear, .cur_slot, .capture, .commit,
    .output_sample, .channel_select
  );

  //----------------------------------------
  // slot array
  //----------------------------------------
  for (genvar i = 0; i < num_slots; i++) begin : g_slot
    channel_slot i_channel_slot (
      .clk, .rst,
      .slot_index (slot_w'(i)),
      .clear, .unit_we, .unit_slot, .unit_chan,
      .cur_slot, .capture, .commit, .sample_data,
      .chan_id    (chan_ids[i]),
      .record     (records[i]),
      .changed    (changed_flags[i])
    );
  end

  sample_store i_sample_store (
    .clk, .rst, .clear, .cur_slot, .commit,
    .records, .changed_flags, .rd_advance,
    .rd_word, .num_samples, .read_ptr
  );

endmodule

// ==== verilog/sample_store.sv ====
//----------------------------------------
// sample memory with change-gated writes
// software drains it through read_ptr, one record per NEXT_SAMPLE read
//----------------------------------------
module sample_store (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic                                                   clear,
  input  logic [sampler_pkg::slot_w-1:0]                         cur_slot,
  input  logic                                                   commit,
  input  logic [sampler_pkg::num_slots-1:0][sampler_pkg::rec_w-1:0] records,
  input  logic [sampler_pkg::num_slots-1:0]                      changed_flags,
  input  logic                                                   rd_advance,
  output logic [sampler_pkg::rec_w-1:0]                          rd_word,
  output logic [sampler_pkg::ptr_w-1:0]                          num_samples,
  output logic [sampler_pkg::ptr_w-1:0]                          read_ptr
);
  import sampler_pkg::*;

  logic [rec_w-1:0]  mem [mem_depth];
  logic [mem_aw-1:0] wr_ptr;
  logic [rec_w-1:0]  sel_record;
  logic              sel_changed;
  logic              wr_en;
  logic              rd_ok;

  assign sel_record  = records[cur_slot];
  assign sel_changed = changed_flags[cur_slot];

  // a full memory just stops taking records
  assign wr_en = commit && sel_changed && (num_samples < ptr_w'(max_samples));

  // read side never passes the write side
  assign rd_ok = rd_advance && (read_ptr < num_samples);

  //----------------------------------------
  // pointers and count
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr      <= '0;
      num_samples <= '0;
      read_ptr    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr      <= wr_ptr + 1'b1;
        num_samples <= num_samples + 1'b1;
      end
      if (rd_ok) begin
        read_ptr <= read_ptr + 1'b1;
      end
    end
  end

  //----------------------------------------
  // dual-port memory
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= sel_record;
    end
  end

  // word at read_ptr is ready one cycle after the pointer moves
  always_ff @(posedge clk) begin
    rd_word <= mem[read_ptr[mem_aw-1:0]];
  end

endmodule

// ==== verilog/channel_slot.sv ====
//----------------------------------------
// one collection slot
// holds its channel, the captured sample and the last stored sample
//----------------------------------------
module channel_slot (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [sampler_pkg::slot_w-1:0]    slot_index,
  input  logic                              clear,
  input  logic                              unit_we,
  input  logic [sampler_pkg::slot_w-1:0]    unit_slot,
  input  logic [sampler_pkg::chan_w-1:0]    unit_chan,
  input  logic [sampler_pkg::slot_w-1:0]    cur_slot,
  input  logic                              capture,
  input  logic                              commit,
  input  logic [sampler_pkg::sample_w-1:0]  sample_data,
  output logic [sampler_pkg::chan_w-1:0]    chan_id,
  output logic [sampler_pkg::rec_w-1:0]     record,
  output logic                              changed
);
  import sampler_pkg::*;

  logic                selected;
  logic [sample_w-1:0] captured;
  logic [sample_w-1:0] last_stored;

  assign selected = (cur_slot == slot_index);

  // last_stored starts at zero so the first nonzero capture counts as new
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      chan_id     <= no_channel;
      captured    <= '0;
      last_stored <= '0;
    end else begin
      if (unit_we && (unit_slot == slot_index)) begin
        chan_id <= unit_chan;
      end
      if (capture && selected) begin
        captured <= sample_data;
      end
      if (commit && selected) begin
        last_stored <= captured;
      end
    end
  end

  assign record  = {slot_index, captured[rec_sample_w-1:0]};
  assign changed = (captured != last_stored);

endmodule

// ==== verilog/collect_fsm.sv ====
//----------------------------------------
// round-robin collection FSM
// strobes the ADC for each registered slot, then captures and commits
//----------------------------------------
module collect_fsm (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  ebi_pkg::cmd_e                                          cmd,
  input  logic [sampler_pkg::slot_w:0]                           num_units,
  input  logic [sampler_pkg::num_slots-1:0][sampler_pkg::chan_w-1:0] chan_ids,
  output logic                                                   cmd_clear,
  output logic                                                   clear,
  output logic [sampler_pkg::slot_w-1:0]                         cur_slot,
  output logic                                                   capture,
  output logic                                                   commit,
  output logic                                                   output_sample,
  output logic [sampler_pkg::chan_w-1:0]                         channel_select
);
  import ebi_pkg::*;
  import sampler_pkg::*;

  state_e state;
  state_e state_nxt;
  logic   at_decision;
  logic   last_slot;

  // commands are only looked at in idle and at the end of a slot
  assign at_decision = (state == st_idle) || (state == st_commit);
  assign cmd_clear   = at_decision && (cmd != cmd_none);
  assign clear       = at_decision && (cmd == cmd_reset);

  assign capture = (state == st_store);
  assign commit  = (state == st_commit);

  assign last_slot = ({1'b0, cur_slot} + 1'b1) >= num_units;

  // no channel is selected while sampling is off
  assign channel_select = (state == st_idle) ? no_channel : chan_ids[cur_slot];

  //----------------------------------------
  // next state
  //----------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        // start with no units registered is dropped
        if ((cmd == cmd_start) && (num_units != '0)) begin
          state_nxt = st_fetch;
        end
      end
      st_fetch: begin
        state_nxt = st_fetch_wait;
      end
      st_fetch_wait: begin
        state_nxt = st_store;
      end
      st_store: begin
        state_nxt = st_commit;
      end
      st_commit: begin
        if ((cmd == cmd_stop) || (cmd == cmd_reset)) begin
          state_nxt = st_idle;
        end else begin
          state_nxt = st_fetch;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= st_idle;
      cur_slot      <= '0;
      output_sample <= 1'b0;
    end else begin
      state         <= state_nxt;
      output_sample <= (state_nxt == st_fetch) || (state_nxt == st_fetch_wait);
      // every run begins at slot 0
      if (state == st_idle) begin
        cur_slot <= '0;
      end else if (commit) begin
        cur_slot <= last_slot ? '0 : cur_slot + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/ebi_port.sv ====
//----------------------------------------
// EBI slave of the sample collector
// decodes unit accesses, holds command and unit count, drives rdata
//----------------------------------------
module ebi_port (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [ebi_pkg::addr_w-1:0]      addr,
  input  logic [ebi_pkg::data_w-1:0]      wdata,
  input  logic                            cs,
  input  logic                            re,
  input  logic                            wr,
  output logic [ebi_pkg::data_w-1:0]      rdata,
  output ebi_pkg::cmd_e                   cmd,
  input  logic                            cmd_clear,
  input  logic                            clear,
  output logic                            unit_we,
  output logic [sampler_pkg::slot_w-1:0]  unit_slot,
  output logic [sampler_pkg::chan_w-1:0]  unit_chan,
  output logic [sampler_pkg::slot_w:0]    num_units,
  output logic                            rd_advance,
  input  logic [sampler_pkg::rec_w-1:0]   rd_word,
  input  logic [sampler_pkg::ptr_w-1:0]   num_samples,
  input  logic [sampler_pkg::ptr_w-1:0]   read_ptr
);
  import ebi_pkg::*;
  import sampler_pkg::*;

  logic       hit;
  logic       rd_hit;
  logic       wr_hit;
  logic [7:0] offset;
  logic [7:0] rd_offset;
  logic [7:0] wr_offset;
  logic       re_d;
  logic       re_dd;
  logic       wr_d;
  logic       wr_dd;
  logic       rd_end;
  logic       wr_end;

  assign hit    = cs && (addr[15:8] == 8'(unit_position));
  assign offset = addr[7:0];
  assign rd_hit = hit && re;
  assign wr_hit = hit && wr;

  // a new write wins over the clear from the FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd <= cmd_none;
    end else if (wr_hit && (offset == reg_command)) begin
      cmd <= cmd_e'(wdata);
    end else if (cmd_clear) begin
      cmd <= cmd_none;
    end
  end

  // offsets are kept so the transaction end sees the right register
  always_ff @(posedge clk) begin
    if (wr_hit && (offset == reg_new_unit)) begin
      unit_chan <= wdata[chan_w-1:0];
    end
    if (rd_hit) begin
      rd_offset <= offset;
    end
    if (wr_hit) begin
      wr_offset <= offset;
    end
  end

  //----------------------------------------
  // transaction end detection
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      re_d  <= 1'b0;
      re_dd <= 1'b0;
      wr_d  <= 1'b0;
      wr_dd <= 1'b0;
    end else begin
      re_d  <= rd_hit;
      re_dd <= re_d;
      wr_d  <= wr_hit;
      wr_dd <= wr_d;
    end
  end

  assign rd_end     = re_dd && !re_d;
  assign wr_end     = wr_dd && !wr_d;
  assign rd_advance = rd_end && (rd_offset == reg_next_sample);

  // next free slot is the current unit count
  assign unit_slot = num_units[slot_w-1:0];
  assign unit_we   = wr_end && (wr_offset == reg_new_unit) &&
                     (num_units < (slot_w + 1)'(num_slots));

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      num_units <= '0;
    end else if (unit_we) begin
      num_units <= num_units + 1'b1;
    end
  end

  //----------------------------------------
  // read mux, zero when no read is seen
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (rst || !rd_hit) begin
      rdata <= '0;
    end else begin
      case (offset)
        reg_next_sample: rdata <= rd_word;
        reg_num_samples: rdata <= num_samples[data_w-1:0];
        reg_read_addr:   rdata <= read_ptr[data_w-1:0];
        reg_command:     rdata <= cmd;
        reg_num_units:   rdata <= data_w'(num_units);
        reg_debug:       rdata <= debug_word;
        default:         rdata <= '0;
      endcase
    end
  end

endmodule

// ==== verilog/sampler_pkg.sv ====
//----------------------------------------
// collector side definitions
// slot count, sample memory size, record layout and FSM states
//----------------------------------------
package sampler_pkg;

  localparam int num_slots = 8;
  localparam int slot_w    = 3;
  localparam int chan_w    = 8;
  localparam int sample_w  = 32;

  // channel value of a slot that has no unit registered
  localparam logic [chan_w-1:0] no_channel = 8'hff;

  //----------------------------------------
  // sample memory
  //----------------------------------------
  localparam int mem_depth   = 1024;
  localparam int mem_aw      = $clog2(mem_depth);
  localparam int ptr_w       = 19;
  localparam int max_samples = mem_depth - 1;

  // record is the slot number above the low sample bits
  localparam int rec_sample_w = 13;
  localparam int rec_w        = slot_w + rec_sample_w;

  typedef enum logic [4:0] {
    st_idle       = 5'b00001,
    st_fetch      = 5'b00010,
    st_fetch_wait = 5'b00100,
    st_store      = 5'b01000,
    st_commit     = 5'b10000
  } state_e;

endpackage

// ==== verilog/ebi_pkg.sv ====
//----------------------------------------
// bus side definitions for the sample collector
// register offsets, unit position and command codes
//----------------------------------------
package ebi_pkg;

  localparam int addr_w = 19;
  localparam int data_w = 16;

  // unit number compared against addr[15:8]
  localparam int unit_position = 242;

  //----------------------------------------
  // register offsets in addr[7:0]
  //----------------------------------------
  localparam logic [7:0] reg_next_sample = 8'd1;
  localparam logic [7:0] reg_num_samples = 8'd2;
  localparam logic [7:0] reg_read_addr   = 8'd3;
  localparam logic [7:0] reg_new_unit    = 8'd4;
  localparam logic [7:0] reg_command     = 8'd5;
  localparam logic [7:0] reg_num_units   = 8'd6;
  localparam logic [7:0] reg_debug       = 8'd10;

  // fixed pattern so software can find the unit
  localparam logic [data_w-1:0] debug_word = 16'hbaab;

  //----------------------------------------
  // commands written to reg_command
  //----------------------------------------
  typedef enum logic [data_w-1:0] {
    cmd_none  = 16'd0,
    cmd_start = 16'd1,
    cmd_stop  = 16'd2,
    cmd_reset = 16'd5
  } cmd_e;

endpackage
